/* periph_config.svh */
// build-wide sizes and codes; GPIO register offsets are word indices in address bits 3:0
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// bus widths
`define PERIPH_DATA_W       32
`define PERIPH_ADDR_W       32

// default pin count of the GPIO block, valid from 1 to 32
`define PERIPH_GPIO_W       8

// default scratch RAM depth in words, power of two from 2 to 256
`define PERIPH_RAM_DEPTH    64

// region codes, compared against address bits 15:8
`define PERIPH_REGION_GPIO  8'h00
`define PERIPH_REGION_RAM   8'h01

// GPIO register word indices
`define PERIPH_GPIO_GPI     4'h0
`define PERIPH_GPIO_GPO     4'h1
`define PERIPH_GPIO_DIR     4'h2

`endif

/* periph_pkg.sv */
// shared bus types; the address layout assumes a bus address of at least 17 bits
`default_nettype none

`include "periph_config.svh"

package periph_pkg;

    // peripheral regions seen by the router
    typedef enum logic [1:0] {
        REGION_GPIO,
        REGION_RAM,
        REGION_UNMAPPED
    } region_e;

    // one address word, offset field read as GPIO register or RAM word
    typedef union packed {
        struct packed {
            logic [`PERIPH_ADDR_W-17 : 0] upper;
            logic [7 : 0]                 region;
            logic [3 : 0]                 unused;
            logic [3 : 0]                 reg_idx;
        } gpio;
        struct packed {
            logic [`PERIPH_ADDR_W-17 : 0] upper;
            logic [7 : 0]                 region;
            logic [7 : 0]                 word_idx;
        } ram;
    } bus_addr_u;

endpackage : periph_pkg

`default_nettype wire

/* periph_gpio.sv */
// gpio_w from 1 to 32; direction is only presented on gpd_o, no pad tri-state inside
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_gpio
    import periph_pkg::*;
#(
    parameter int gpio_w = `PERIPH_GPIO_W
)(
    input  logic                         clk,
    input  logic                         resetn,
    // router side
    input  logic                         we_i,
    input  bus_addr_u                    idx_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  wd_i,
    output logic [`PERIPH_DATA_W-1 : 0]  rd_o,
    // pin side
    input  logic [gpio_w-1 : 0]          gpi_i,
    output logic [gpio_w-1 : 0]          gpo_o,
    output logic [gpio_w-1 : 0]          gpd_o
);
    logic [gpio_w-1 : 0] gpi_meta;
    logic [gpio_w-1 : 0] gpi_sync;
    logic [gpio_w-1 : 0] gpo_q;
    logic [gpio_w-1 : 0] gpd_q;
    logic                gpo_we;
    logic                gpd_we;

    assign gpo_o = gpo_q;
    assign gpd_o = gpd_q;

    // register select from the gpio view of the offset
    assign gpo_we = we_i && (idx_i.gpio.reg_idx == `PERIPH_GPIO_GPO);
    assign gpd_we = we_i && (idx_i.gpio.reg_idx == `PERIPH_GPIO_DIR);

    // two-flop synchronizer on the input pins
    always_ff @(posedge clk, negedge resetn)
    begin : sync_gpi
        if (!resetn)
        begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end
        else
        begin
            gpi_meta <= gpi_i;
            gpi_sync <= gpi_meta;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin : load_regs
        if (!resetn)
        begin
            gpo_q <= '0;
            gpd_q <= '0;
        end
        else
        begin
            // upper data bits beyond the pin count are dropped
            if (gpo_we)
                gpo_q <= wd_i[gpio_w-1 : 0];
            if (gpd_we)
                gpd_q <= wd_i[gpio_w-1 : 0];
        end
    end

    // read mux, zero extended; unknown indices fall back to the input value
    always_comb
    begin
        rd_o = '0;
        case (idx_i.gpio.reg_idx)
            `PERIPH_GPIO_GPO : rd_o[gpio_w-1 : 0] = gpo_q;
            `PERIPH_GPIO_DIR : rd_o[gpio_w-1 : 0] = gpd_q;
            default          : rd_o[gpio_w-1 : 0] = gpi_sync;
        endcase
    end

endmodule : periph_gpio

`default_nettype wire

/* periph_ram.sv */
// depth must be a power of two from 2 to 256; word indices wrap modulo depth, no reset of contents
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_ram
    import periph_pkg::*;
#(
    parameter int depth = `PERIPH_RAM_DEPTH
)(
    input  logic                         clk,
    input  logic                         we_i,
    input  bus_addr_u                    idx_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  wd_i,
    output logic [`PERIPH_DATA_W-1 : 0]  rd_o
);
    localparam int aw = $clog2(depth);

    logic [`PERIPH_DATA_W-1 : 0] mem [depth];
    logic [aw-1 : 0]             word;

    // low bits of the ram view give the wrap
    assign word = idx_i.ram.word_idx[aw-1 : 0];

    always_ff @(posedge clk)
    begin : write_port
        if (we_i)
            mem[word] <= wd_i;
    end

    // asynchronous read, valid in the granted cycle
    assign rd_o = mem[word];

endmodule : periph_ram

`default_nettype wire

/* bus_arbiter.sv */
// grant is combinational from the requests; the pointer only moves on a contended cycle
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module bus_arbiter
(
    input  logic                         clk,
    input  logic                         resetn,
    // port a
    input  logic                         a_req_i,
    input  logic                         a_we_i,
    input  logic [`PERIPH_ADDR_W-1 : 0]  a_addr_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  a_wd_i,
    output logic                         a_gnt_o,
    output logic [`PERIPH_DATA_W-1 : 0]  a_rd_o,
    // port b
    input  logic                         b_req_i,
    input  logic                         b_we_i,
    input  logic [`PERIPH_ADDR_W-1 : 0]  b_addr_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  b_wd_i,
    output logic                         b_gnt_o,
    output logic [`PERIPH_DATA_W-1 : 0]  b_rd_o,
    // shared bus
    output logic                         bus_we_o,
    output logic [`PERIPH_ADDR_W-1 : 0]  bus_addr_o,
    output logic [`PERIPH_DATA_W-1 : 0]  bus_wd_o,
    input  logic [`PERIPH_DATA_W-1 : 0]  bus_rd_i
);
    // low means port a has priority
    logic prio_b;
    logic contend;

    assign contend = a_req_i && b_req_i;

    // a lone request wins at once, a tie goes to the pointer
    assign a_gnt_o = a_req_i && (!b_req_i || !prio_b);
    assign b_gnt_o = b_req_i && (!a_req_i || prio_b);

    always_ff @(posedge clk, negedge resetn)
    begin : rr_pointer
        if (!resetn)
            prio_b <= 1'b0;
        else if (contend)
            // hand priority to the loser
            prio_b <= a_gnt_o;
    end

    // winner onto the bus, port a when idle
    always_comb
    begin
        if (b_gnt_o)
        begin
            bus_addr_o = b_addr_i;
            bus_wd_o   = b_wd_i;
        end
        else
        begin
            bus_addr_o = a_addr_i;
            bus_wd_o   = a_wd_i;
        end
    end

    // write strobe only for a granted write
    assign bus_we_o = (a_gnt_o && a_we_i) || (b_gnt_o && b_we_i);

    // both ports see read data, valid only while granted
    assign a_rd_o = bus_rd_i;
    assign b_rd_o = bus_rd_i;

endmodule : bus_arbiter

`default_nettype wire

/* addr_router.sv */
// region taken from address bits 15:8 only, upper bits alias; unmapped writes drop, reads give zero
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module addr_router
    import periph_pkg::*;
(
    // shared bus
    input  logic                         bus_we_i,
    input  logic [`PERIPH_ADDR_W-1 : 0]  bus_addr_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  bus_wd_i,
    output logic [`PERIPH_DATA_W-1 : 0]  bus_rd_o,
    // gpio peer
    output logic                         gpio_we_o,
    output bus_addr_u                    gpio_idx_o,
    input  logic [`PERIPH_DATA_W-1 : 0]  gpio_rd_i,
    // ram peer
    output logic                         ram_we_o,
    output bus_addr_u                    ram_idx_o,
    input  logic [`PERIPH_DATA_W-1 : 0]  ram_rd_i,
    // write data common to both peers
    output logic [`PERIPH_DATA_W-1 : 0]  wd_o
);
    bus_addr_u addr;
    region_e   region;

    assign addr = bus_addr_i;

    // classify the region byte
    always_comb
    begin
        case (addr.gpio.region)
            `PERIPH_REGION_GPIO : region = REGION_GPIO;
            `PERIPH_REGION_RAM  : region = REGION_RAM;
            default             : region = REGION_UNMAPPED;
        endcase
    end

    assign gpio_we_o = bus_we_i && (region == REGION_GPIO);
    assign ram_we_o  = bus_we_i && (region == REGION_RAM);
    assign wd_o      = bus_wd_i;

    // each peer gets only its own offset view, rest zeroed
    always_comb
    begin
        gpio_idx_o              = '0;
        gpio_idx_o.gpio.reg_idx = addr.gpio.reg_idx;
        ram_idx_o               = '0;
        ram_idx_o.ram.word_idx  = addr.ram.word_idx;
    end

    // read data select
    always_comb
    begin
        case (region)
            REGION_GPIO : bus_rd_o = gpio_rd_i;
            REGION_RAM  : bus_rd_o = ram_rd_i;
            default     : bus_rd_o = '0;
        endcase
    end

endmodule : addr_router

`default_nettype wire

/* periph_subsys.sv */
// two masters share one bus; a write shows on the pins one edge after its granted edge
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_subsys
    import periph_pkg::*;
(
    input  logic                         clk,
    input  logic                         resetn,
    // master port a
    input  logic                         a_req_i,
    input  logic                         a_we_i,
    input  logic [`PERIPH_ADDR_W-1 : 0]  a_addr_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  a_wd_i,
    output logic                         a_gnt_o,
    output logic [`PERIPH_DATA_W-1 : 0]  a_rd_o,
    // master port b
    input  logic                         b_req_i,
    input  logic                         b_we_i,
    input  logic [`PERIPH_ADDR_W-1 : 0]  b_addr_i,
    input  logic [`PERIPH_DATA_W-1 : 0]  b_wd_i,
    output logic                         b_gnt_o,
    output logic [`PERIPH_DATA_W-1 : 0]  b_rd_o,
    // gpio pins
    input  logic [`PERIPH_GPIO_W-1 : 0]  gpi_i,
    output logic [`PERIPH_GPIO_W-1 : 0]  gpo_o,
    output logic [`PERIPH_GPIO_W-1 : 0]  gpd_o
);
    // shared bus
    logic                         bus_we;
    logic [`PERIPH_ADDR_W-1 : 0]  bus_addr;
    logic [`PERIPH_DATA_W-1 : 0]  bus_wd;
    logic [`PERIPH_DATA_W-1 : 0]  bus_rd;

    // router to peers
    logic                         gpio_we;
    bus_addr_u                    gpio_idx;
    logic [`PERIPH_DATA_W-1 : 0]  gpio_rd;
    logic                         ram_we;
    bus_addr_u                    ram_idx;
    logic [`PERIPH_DATA_W-1 : 0]  ram_rd;
    logic [`PERIPH_DATA_W-1 : 0]  peer_wd;

    bus_arbiter u_bus_arbiter
    (
        .clk        ( clk      ),
        .resetn     ( resetn   ),
        .a_req_i    ( a_req_i  ),
        .a_we_i     ( a_we_i   ),
        .a_addr_i   ( a_addr_i ),
        .a_wd_i     ( a_wd_i   ),
        .a_gnt_o    ( a_gnt_o  ),
        .a_rd_o     ( a_rd_o   ),
        .b_req_i    ( b_req_i  ),
        .b_we_i     ( b_we_i   ),
        .b_addr_i   ( b_addr_i ),
        .b_wd_i     ( b_wd_i   ),
        .b_gnt_o    ( b_gnt_o  ),
        .b_rd_o     ( b_rd_o   ),
        .bus_we_o   ( bus_we   ),
        .bus_addr_o ( bus_addr ),
        .bus_wd_o   ( bus_wd   ),
        .bus_rd_i   ( bus_rd   )
    );

    addr_router u_addr_router
    (
        .bus_we_i   ( bus_we   ),
        .bus_addr_i ( bus_addr ),
        .bus_wd_i   ( bus_wd   ),
        .bus_rd_o   ( bus_rd   ),
        .gpio_we_o  ( gpio_we  ),
        .gpio_idx_o ( gpio_idx ),
        .gpio_rd_i  ( gpio_rd  ),
        .ram_we_o   ( ram_we   ),
        .ram_idx_o  ( ram_idx  ),
        .ram_rd_i   ( ram_rd   ),
        .wd_o       ( peer_wd  )
    );

    periph_gpio
    #(
        .gpio_w     ( `PERIPH_GPIO_W )
    )
    u_periph_gpio
    (
        .clk        ( clk      ),
        .resetn     ( resetn   ),
        .we_i       ( gpio_we  ),
        .idx_i      ( gpio_idx ),
        .wd_i       ( peer_wd  ),
        .rd_o       ( gpio_rd  ),
        .gpi_i      ( gpi_i    ),
        .gpo_o      ( gpo_o    ),
        .gpd_o      ( gpd_o    )
    );

    periph_ram
    #(
        .depth      ( `PERIPH_RAM_DEPTH )
    )
    u_periph_ram
    (
        .clk        ( clk     ),
        .we_i       ( ram_we  ),
        .idx_i      ( ram_idx ),
        .wd_i       ( peer_wd ),
        .rd_o       ( ram_rd  )
    );

endmodule : periph_subsys

`default_nettype wire

/* periph_subsys_sva.sv */
// bound into every bus_arbiter instance; checks are off while resetn is low
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_sva
(
    input logic clk,
    input logic resetn,
    input logic a_req_i,
    input logic b_req_i,
    input logic a_gnt_i,
    input logic b_gnt_i
);
    logic contend;

    // count of failed assertions
    int   fails = 0;

    assign contend = a_req_i && b_req_i;

    gnt_exclusive : assert property (@(posedge clk) disable iff (!resetn)
        !(a_gnt_i && b_gnt_i))
        else
        begin
            $error("both ports granted in the same cycle");
            fails++;
        end

    a_gnt_has_req : assert property (@(posedge clk) disable iff (!resetn) a_gnt_i |-> a_req_i)
        else
        begin
            $error("port a granted without a request");
            fails++;
        end

    b_gnt_has_req : assert property (@(posedge clk) disable iff (!resetn) b_gnt_i |-> b_req_i)
        else
        begin
            $error("port b granted without a request");
            fails++;
        end

    // loser of a contended cycle wins the next one while contention lasts
    rr_a_then_b : assert property (@(posedge clk) disable iff (!resetn)
        (contend && a_gnt_i) ##1 contend |-> b_gnt_i)
        else
        begin
            $error("port b lost twice in a row under contention");
            fails++;
        end

    rr_b_then_a : assert property (@(posedge clk) disable iff (!resetn)
        (contend && b_gnt_i) ##1 contend |-> a_gnt_i)
        else
        begin
            $error("port a lost twice in a row under contention");
            fails++;
        end

endmodule : periph_subsys_sva

bind bus_arbiter periph_subsys_sva u_periph_subsys_sva
(
    .clk     ( clk     ),
    .resetn  ( resetn  ),
    .a_req_i ( a_req_i ),
    .b_req_i ( b_req_i ),
    .a_gnt_i ( a_gnt_o ),
    .b_gnt_i ( b_gnt_o )
);

`default_nettype wire

/* periph_subsys_tb.sv */
// assumes PERIPH_ADDR_W and PERIPH_DATA_W of 32; the RAM has no reset, so it is filled before random reads
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_subsys_tb
    import periph_pkg::*;
();
    localparam int depth       = `PERIPH_RAM_DEPTH;
    localparam int gnt_timeout = 16;

    logic                        clk;
    logic                        resetn;
    logic                        a_req, a_we, b_req, b_we;
    logic [`PERIPH_ADDR_W-1 : 0] a_addr, b_addr;
    logic [`PERIPH_DATA_W-1 : 0] a_wd, b_wd, a_rd_o, b_rd_o;
    logic                        a_gnt_o, b_gnt_o;
    logic [`PERIPH_GPIO_W-1 : 0] gpi, gpo_o, gpd_o;

    // model of the register block, the input synchronizer and the RAM
    logic [`PERIPH_GPIO_W-1 : 0] gpo_m, gpd_m, gpi_d1, gpi_d2;
    logic [`PERIPH_DATA_W-1 : 0] ram_m [depth];
    logic [31 : 0]               rng;
    int                          checks, errors, timeouts;
    string                       test_name;
    int                          done_order [$];

    periph_subsys u_periph_subsys
    (
        .clk      ( clk     ), .resetn   ( resetn  ),
        .a_req_i  ( a_req   ), .a_we_i   ( a_we    ),
        .a_addr_i ( a_addr  ), .a_wd_i   ( a_wd    ),
        .a_gnt_o  ( a_gnt_o ), .a_rd_o   ( a_rd_o  ),
        .b_req_i  ( b_req   ), .b_we_i   ( b_we    ),
        .b_addr_i ( b_addr  ), .b_wd_i   ( b_wd    ),
        .b_gnt_o  ( b_gnt_o ), .b_rd_o   ( b_rd_o  ),
        .gpi_i    ( gpi     ), .gpo_o    ( gpo_o   ),
        .gpd_o    ( gpd_o   )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // a pin value reaches the input register two edges later
    always @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            gpi_d1 <= '0;
            gpi_d2 <= '0;
        end
        else
        begin
            gpi_d1 <= gpi;
            gpi_d2 <= gpi_d1;
        end
    end

    function automatic logic [31 : 0] xorshift32(input logic [31 : 0] s);
        logic [31 : 0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31 : 0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [`PERIPH_ADDR_W-1 : 0] make_addr(input logic [7 : 0] region,
                                                              input logic [7 : 0] offset);
        return {{(`PERIPH_ADDR_W-16){1'b0}}, region, offset};
    endfunction

    function automatic region_e region_of(input bus_addr_u a);
        if (a.gpio.region == `PERIPH_REGION_GPIO)
            return REGION_GPIO;
        if (a.gpio.region == `PERIPH_REGION_RAM)
            return REGION_RAM;
        return REGION_UNMAPPED;
    endfunction

    // expected read data for an address, from the model state
    function automatic logic [`PERIPH_DATA_W-1 : 0] exp_read(input bus_addr_u a);
        logic [`PERIPH_DATA_W-1 : 0] rd;
        rd = '0;
        if (region_of(a) == REGION_RAM)
            rd = ram_m[a.ram.word_idx % depth];
        else if (region_of(a) == REGION_GPIO)
        begin
            case (a.gpio.reg_idx)
                `PERIPH_GPIO_GPO : rd = `PERIPH_DATA_W'(gpo_m);
                `PERIPH_GPIO_DIR : rd = `PERIPH_DATA_W'(gpd_m);
                default          : rd = `PERIPH_DATA_W'(gpi_d2);
            endcase
        end
        return rd;
    endfunction

    task automatic apply_write(input bus_addr_u a, input logic [`PERIPH_DATA_W-1 : 0] wd);
        if (region_of(a) == REGION_RAM)
            ram_m[a.ram.word_idx % depth] = wd;
        else if (region_of(a) == REGION_GPIO && a.gpio.reg_idx == `PERIPH_GPIO_GPO)
            gpo_m = wd[`PERIPH_GPIO_W-1 : 0];
        else if (region_of(a) == REGION_GPIO && a.gpio.reg_idx == `PERIPH_GPIO_DIR)
            gpd_m = wd[`PERIPH_GPIO_W-1 : 0];
    endtask

    task automatic check(input string name, input logic [31 : 0] exp, input logic [31 : 0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one access on a port; returns at the granted edge
    task automatic bus_access(input bit port_b, input bit we, input logic [31 : 0] addr,
                              input logic [31 : 0] wd, output int waited);
        int  cycles;
        bit  granted;
        @(posedge clk);
        if (port_b)
            {b_req, b_we, b_addr, b_wd} <= {1'b1, we, addr, wd};
        else
            {a_req, a_we, a_addr, a_wd} <= {1'b1, we, addr, wd};
        cycles  = 0;
        granted = 1'b0;
        while (!granted && cycles < gnt_timeout)
        begin
            @(posedge clk);
            cycles++;
            granted = port_b ? b_gnt_o : a_gnt_o;
        end
        if (port_b)
            b_req <= 1'b0;
        else
            a_req <= 1'b0;
        waited = cycles - 1;
        if (!granted)
        begin
            timeouts++;
            $display("port %s got no grant within %0d cycles during %s",
                     port_b ? "b" : "a", gnt_timeout, test_name);
        end
        else
        begin
            if (we)
                apply_write(addr, wd);
            done_order.push_back(int'(port_b));
        end
    endtask

    always @(negedge clk)
    begin : compare_reads
        if (resetn && a_gnt_o && !a_we)
            check({test_name, " read a"}, exp_read(a_addr), a_rd_o);
        if (resetn && b_gnt_o && !b_we)
            check({test_name, " read b"}, exp_read(b_addr), b_rd_o);
    end

    initial
    begin : main
        int            w, wa, wb;
        int            sva_fails;
        logic [31 : 0] d_a, d_b, addr_a, addr_b;
        {a_req, a_we, a_addr, a_wd, b_req, b_we, b_addr, b_wd} = '0;
        gpi    = '0;
        resetn = 1'b0;
        rng    = 32'h7d95;
        {gpo_m, gpd_m, checks, errors, timeouts} = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        test_name = "reset";
        @(negedge clk);
        check("reset gpo pins", '0, 32'(gpo_o));
        check("reset gpd pins", '0, 32'(gpd_o));
        bus_access(0, 0, make_addr(`PERIPH_REGION_GPIO, `PERIPH_GPIO_GPO), '0, w);
        bus_access(1, 0, make_addr(`PERIPH_REGION_GPIO, `PERIPH_GPIO_DIR), '0, w);

        test_name = "gpio write";
        for (int i = 0; i < 6; i++)
        begin
            d_a    = rand32();
            addr_a = make_addr(`PERIPH_REGION_GPIO, i[1] ? `PERIPH_GPIO_DIR : `PERIPH_GPIO_GPO);
            bus_access(i[0], 1, addr_a, d_a, w);
            @(negedge clk);
            check("gpo pins", 32'(gpo_m), 32'(gpo_o));
            check("gpd pins", 32'(gpd_m), 32'(gpd_o));
            bus_access(!i[0], 0, addr_a, '0, w);
        end

        test_name = "gpio input";
        for (int i = 0; i < 6; i++)
        begin
            d_a = rand32();
            @(posedge clk);
            gpi <= d_a[`PERIPH_GPIO_W-1 : 0];
            // read one, two or three edges after the pin change
            repeat (i % 3) @(posedge clk);
            bus_access(i[0], 0, make_addr(`PERIPH_REGION_GPIO, `PERIPH_GPIO_GPI), '0, w);
        end

        // every word once, through aliased indices above depth
        test_name = "ram fill";
        for (int i = 0; i < depth; i++)
            bus_access(i[0], 1, make_addr(`PERIPH_REGION_RAM, 8'(i + depth * (i % 4))),
                       32'hc0de_0000 ^ (i * 32'h0101_0101), w);
        test_name = "ram random";
        for (int i = 0; i < 40; i++)
        begin
            d_a = rand32();
            d_b = rand32();
            bus_access(d_a[31], d_a[30], make_addr(`PERIPH_REGION_RAM, d_a[7 : 0]), d_b, w);
        end

        test_name = "contention";
        for (int k = 0; k < 8; k++)
        begin
            d_a    = rand32();
            d_b    = rand32();
            addr_a = make_addr(`PERIPH_REGION_RAM, d_a[7 : 0]);
            addr_b = make_addr(`PERIPH_REGION_RAM, d_b[7 : 0]);
            done_order.delete();
            fork
                bus_access(0, d_a[8], addr_a, d_b, wa);
                bus_access(1, d_b[8], addr_b, d_a, wb);
            join
            // pointer starts at port a and flips on every contended edge
            check("round grants", 2, done_order.size());
            check("round winner", k % 2, done_order[0]);
            check("round loser wait", 1, (k % 2) ? wa : wb);
        end

        // both ports hold a read; after an even number of rounds port a leads
        test_name = "held contention";
        @(posedge clk);
        {a_req, a_we, a_addr} <= {1'b1, 1'b0, make_addr(`PERIPH_REGION_RAM, d_a[7 : 0])};
        {b_req, b_we, b_addr} <= {1'b1, 1'b0, make_addr(`PERIPH_REGION_RAM, d_b[7 : 0])};
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clk);
            check("held grant a", (i % 2) == 0, a_gnt_o);
            check("held grant b", (i % 2) == 1, b_gnt_o);
        end
        a_req <= 1'b0;
        b_req <= 1'b0;

        test_name = "ram sweep";
        for (int i = 0; i < depth; i++)
            bus_access(i[0], 0, make_addr(`PERIPH_REGION_RAM, 8'(i)), '0, w);

        test_name = "unmapped";
        for (int i = 0; i < 8; i++)
        begin
            d_a    = rand32();
            addr_a = make_addr(d_a[15 : 8] | 8'h02, 8'(i % 3));
            bus_access(i[0], 1, addr_a, rand32(), w);
            @(negedge clk);
            check("unmapped gpo pins", 32'(gpo_m), 32'(gpo_o));
            check("unmapped gpd pins", 32'(gpd_m), 32'(gpd_o));
            bus_access(!i[0], 0, addr_a, '0, w);
        end
        for (int i = 0; i < 3; i++)
            bus_access(0, 0, make_addr(`PERIPH_REGION_RAM, 8'(i)), '0, w);

        repeat (2) @(posedge clk);
        sva_fails = u_periph_subsys.u_bus_arbiter.u_periph_subsys_sva.fails;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : periph_subsys_tb

`default_nettype wire

/* list.f */
+incdir+.
periph_pkg.sv
periph_gpio.sv
periph_ram.sv
bus_arbiter.sv
addr_router.sv
periph_subsys.sv
periph_subsys_sva.sv
periph_subsys_tb.sv

/* Bender.yml */
package:
  name: periph_subsys

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - periph_gpio.sv
      - periph_ram.sv
      - bus_arbiter.sv
      - addr_router.sv
      - periph_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - periph_subsys_sva.sv
      - periph_subsys_tb.sv
